// ==== space_invaders_pkg.sv ====
package space_invaders_pkg;

    // VGA 640x400 timing, in screen pixels and lines
    localparam int ACTIVE_H = 640;
    localparam int FRONT_H  = 16;
    localparam int SYNC_H   = 96;
    localparam int BACK_H   = 48;
    localparam int ACTIVE_V = 400;
    localparam int FRONT_V  = 12;
    localparam int SYNC_V   = 2;
    localparam int BACK_V   = 35;

    localparam int MAX_H = ACTIVE_H + FRONT_H + SYNC_H + BACK_H;  // 800
    localparam int MAX_V = ACTIVE_V + FRONT_V + SYNC_V + BACK_V;  // 449

    // Game field, one game pixel is 2x2 screen pixels
    localparam int FIELD_W      = 320;
    localparam int FIELD_H      = 200;
    localparam int FIRST_COLUMN = 4;
    localparam int LAST_COLUMN  = 320;

    localparam int CANNON_POS_Y      = 181;  // Just below the last invader row
    localparam int CANNON_W          = 15;
    localparam int CANNON_H          = 8;
    localparam int CANNON_STEP_DELAY = 4096;

    // PS/2 set 2 scan codes
    localparam logic [7:0] KEY_LEFT  = 8'h1C;  // A
    localparam logic [7:0] KEY_RIGHT = 8'h23;  // D
    localparam logic [7:0] KEY_BREAK = 8'hF0;

    typedef struct packed {
        logic [9:0] h;
        logic [8:0] v;
    } scan_pos_t;

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } vga_color_t;

    typedef enum logic [1:0] {
        NO_ACTION,
        MOVE_LEFT,
        MOVE_RIGHT
    } cannon_action_e;

    typedef logic [8:0] field_x_t;

endpackage

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
    import space_invaders_pkg::*;
(
    input  logic      clk,
    input  logic      reset_game,
    output scan_pos_t scan_pos,
    output logic      hsync,
    output logic      vsync,
    output logic      line_req
);

    logic      pix_en;  // Beam moves on every second clk
    scan_pos_t pos;

    always_ff @(posedge clk) begin
        if (reset_game) begin
            pix_en <= 1'b0;
            pos    <= '0;
        end else begin
            pix_en <= !pix_en;
            if (pix_en) begin
                if (pos.h == 10'(MAX_H - 1)) begin
                    pos.h <= '0;
                    if (pos.v == 9'(MAX_V - 1)) begin
                        pos.v <= '0;
                    end else begin
                        pos.v <= pos.v + 9'd1;
                    end
                end else begin
                    pos.h <= pos.h + 10'd1;
                end
            end
        end
    end

    assign scan_pos = pos;

    // Both syncs active high
    assign hsync = (pos.h >= 10'(ACTIVE_H + FRONT_H))
                && (pos.h <  10'(ACTIVE_H + FRONT_H + SYNC_H));
    assign vsync = (pos.v >= 9'(ACTIVE_V + FRONT_V))
                && (pos.v <  9'(ACTIVE_V + FRONT_V + SYNC_V));

    // h sits on ACTIVE_H for two clks, pix_en keeps the strobe one clk wide.
    // Only even lines, the odd line repeats the same game line.
    assign line_req = pix_en
                   && (pos.h == 10'(ACTIVE_H))
                   && !pos.v[0]
                   && (pos.v < 9'(ACTIVE_V - 2));

endmodule

// ==== ps2_receiver.sv ====
`timescale 1ns/1ps

module ps2_receiver
    import space_invaders_pkg::*;
(
    input  logic       clk,
    input  logic       reset_game,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    logic [2:0] clk_sync;   // [0] is the first stage
    logic [1:0] data_sync;
    logic [3:0] bit_cnt;    // 0 start, 1..8 data, 9 parity, 10 stop
    logic [8:0] shift;      // Data bits and parity, LSB first
    logic       clk_fall;
    logic       data_bit;

    assign clk_fall = !clk_sync[1] && clk_sync[2];
    assign data_bit = data_sync[1];

    always_ff @(posedge clk) begin
        if (reset_game) begin
            clk_sync   <= 3'b111;  // Idle lines are high
            data_sync  <= 2'b11;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[1:0], ps2_clk};
            data_sync  <= {data_sync[0], ps2_data};
            byte_valid <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == 4'd0) begin
                    // Wait here until a real start bit shows up
                    if (!data_bit) begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;
                    if (data_bit) begin  // Good stop bit
                        byte_valid <= 1'b1;
                        byte_data  <= shift[7:0];
                    end
                end else begin
                    shift   <= {data_bit, shift[8:1]};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // Parity sits in shift[8] and is ignored

endmodule

// ==== player_input.sv ====
`timescale 1ns/1ps

module player_input
    import space_invaders_pkg::*;
(
    input  logic           clk,
    input  logic           reset_game,
    input  logic [3:0]     btn,
    input  logic           byte_valid,
    input  logic [7:0]     byte_data,
    output cannon_action_e action,
    output logic [7:0]     led
);

    // Only btn 0 (right) and btn 3 (left) take part, packed as {left, right}
    logic [1:0] btn_s1, btn_s2, btn_s3;
    logic       held_left;
    logic       held_right;
    logic       break_pending;  // Last byte was F0

    always_ff @(posedge clk) begin
        if (reset_game) begin
            btn_s1        <= '0;
            btn_s2        <= '0;
            btn_s3        <= '0;
            held_left     <= 1'b0;
            held_right    <= 1'b0;
            break_pending <= 1'b0;
            led           <= '0;
        end else begin
            btn_s1 <= {btn[3], btn[0]};
            btn_s2 <= btn_s1;
            btn_s3 <= btn_s2;
            if (byte_valid) begin
                led           <= byte_data;
                break_pending <= 1'b0;
                case (byte_data)
                    KEY_BREAK: break_pending <= 1'b1;
                    KEY_LEFT:  held_left     <= !break_pending;  // Make sets, break clears
                    KEY_RIGHT: held_right    <= !break_pending;
                    default: ;
                endcase
            end
        end
    end

    // Right wins when both are held
    assign action = (btn_s3[0] || held_right) ? MOVE_RIGHT :
                    (btn_s3[1] || held_left)  ? MOVE_LEFT  : NO_ACTION;

endmodule

// ==== cannon_ctrl.sv ====
`timescale 1ns/1ps

module cannon_ctrl
    import space_invaders_pkg::*;
(
    input  logic           clk,
    input  logic           reset_game,
    input  cannon_action_e action,
    output field_x_t       cannon_x
);

    logic [$clog2(CANNON_STEP_DELAY + 1)-1:0] delay_cnt;

    always_ff @(posedge clk) begin
        if (reset_game) begin
            delay_cnt <= '0;
            cannon_x  <= field_x_t'(FIRST_COLUMN);
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end else if (action != NO_ACTION) begin
            // Delay restarts even when the cannon sits at a limit
            delay_cnt <= ($bits(delay_cnt))'(CANNON_STEP_DELAY);
            if (action == MOVE_LEFT && cannon_x > field_x_t'(FIRST_COLUMN)) begin
                cannon_x <= cannon_x - field_x_t'(1);
            end
            if (action == MOVE_RIGHT && cannon_x < field_x_t'(LAST_COLUMN - CANNON_W)) begin
                cannon_x <= cannon_x + field_x_t'(1);
            end
        end
    end

endmodule

// ==== line_renderer.sv ====
`timescale 1ns/1ps

module line_renderer
    import space_invaders_pkg::*;
(
    input  logic      clk,
    input  logic      reset_game,
    input  scan_pos_t scan_pos,
    input  logic      line_req,
    input  field_x_t  cannon_x,
    output logic      pixel
);

    // Two game lines, even and odd, the beam reads one while the next is drawn
    logic cache [2][FIELD_W];

    logic                       busy;
    field_x_t                   wr_col;
    logic [$clog2(FIELD_H)-1:0] wr_row;
    logic                       hit;
    logic                       active;
    field_x_t                   rd_col;

    // Cannon is a solid block
    assign hit = (wr_row >= 8'(CANNON_POS_Y))
              && (wr_row <  8'(CANNON_POS_Y + CANNON_H))
              && (wr_col >= cannon_x)
              && (wr_col <  cannon_x + field_x_t'(CANNON_W));

    always_ff @(posedge clk) begin
        if (reset_game) begin
            busy   <= 1'b0;
            wr_col <= '0;
        end else if (line_req) begin
            busy   <= 1'b1;
            wr_col <= '0;
            wr_row <= scan_pos.v[8:1] + 8'd1;  // One game line ahead of the beam
        end else if (busy) begin
            cache[wr_row[0]][wr_col] <= hit;
            wr_col <= wr_col + field_x_t'(1);
            if (wr_col == field_x_t'(FIELD_W - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    assign active = (scan_pos.h < 10'(ACTIVE_H)) && (scan_pos.v < 9'(ACTIVE_V));
    assign rd_col = active ? scan_pos.h[9:1] : '0;  // Keep the index inside the line

    always_ff @(posedge clk) begin
        if (reset_game) begin
            pixel <= 1'b0;
        end else begin
            pixel <= active && cache[scan_pos.v[1]][rd_col];  // Blank outside the picture
        end
    end

endmodule

// ==== space_invaders.sv ====
`timescale 1ns/1ps

module space_invaders
    import space_invaders_pkg::*;
(
    input  logic       clk,
    input  logic       reset_game,
    input  logic [3:0] btn,       // 0 right, 3 left
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       hsync,
    output logic       vsync,
    output vga_color_t vga,
    output logic [7:0] led
);

    scan_pos_t      scan_pos;
    logic           line_req;
    logic           byte_valid;
    logic [7:0]     byte_data;
    cannon_action_e action;
    field_x_t       cannon_x;
    logic           pixel;

    vga_timing i_vga_timing (
        .clk        (clk),
        .reset_game (reset_game),
        .scan_pos   (scan_pos),
        .hsync      (hsync),
        .vsync      (vsync),
        .line_req   (line_req)
    );

    ps2_receiver i_ps2_receiver (
        .clk        (clk),
        .reset_game (reset_game),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    player_input i_player_input (
        .clk        (clk),
        .reset_game (reset_game),
        .btn        (btn),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .action     (action),
        .led        (led)
    );

    cannon_ctrl i_cannon_ctrl (
        .clk        (clk),
        .reset_game (reset_game),
        .action     (action),
        .cannon_x   (cannon_x)
    );

    line_renderer i_line_renderer (
        .clk        (clk),
        .reset_game (reset_game),
        .scan_pos   (scan_pos),
        .line_req   (line_req),
        .cannon_x   (cannon_x),
        .pixel      (pixel)
    );

    // Monochrome output, lit pixels are full white
    always_ff @(posedge clk) begin
        if (reset_game) begin
            vga <= '0;
        end else if (pixel) begin
            vga <= '{r: 3'h7, g: 3'h7, b: 2'h3};
        end else begin
            vga <= '0;
        end
    end

endmodule

// ==== tb_space_invaders.sv ====
`timescale 1ns/1ps

module tb_space_invaders
    import space_invaders_pkg::*;
;

    localparam longint FRAME_CLKS = 2 * MAX_H * MAX_V;
    localparam longint TIMEOUT_NS = FRAME_CLKS * 8 * 11 / 10 * 4;  // Eight frames plus 10 %
    localparam vga_color_t WHITE  = '{r: 3'h7, g: 3'h7, b: 2'h3};

    logic       clk = 1'b0;
    logic       reset_game;
    logic [3:0] btn;
    logic       ps2_clk;
    logic       ps2_data;
    logic       hsync;
    logic       vsync;
    vga_color_t vga;
    logic [7:0] led;

    int errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    // Monitor state, all in clks
    int   clk_cnt = 0;
    int   hs_rise_t = -1;
    int   vs_rise_t = -1;
    int   hs_period, hs_high, vs_period, vs_high;
    int   since_hfall = 0;
    int   row_len = 0;
    int   row_start = 0;
    int   lit_rows = 0;
    int   first_start = -1;
    int   bad_len = 0;
    int   bad_start = 0;
    int   not_white = 0;
    int   frame_rows, frame_start, frame_bad_len, frame_bad_start, frame_not_white;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    event frame_done;

    always #2 clk = !clk;

    space_invaders i_space_invaders (
        .clk        (clk),
        .reset_game (reset_game),
        .btn        (btn),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .hsync      (hsync),
        .vsync      (vsync),
        .vga        (vga),
        .led        (led)
    );

    // Outputs sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin
        clk_cnt++;
        since_hfall++;
        if (vga != '0) begin
            if (row_len == 0) row_start = since_hfall;
            row_len++;
            if (vga != WHITE) not_white++;
        end
        if (hsync && !hs_prev) begin
            if (hs_rise_t >= 0) hs_period = clk_cnt - hs_rise_t;
            hs_rise_t = clk_cnt;
        end
        if (!hsync && hs_prev) begin
            hs_high = clk_cnt - hs_rise_t;
            if (row_len > 0) begin  // Close the row
                lit_rows++;
                if (row_len != CANNON_W * 4) bad_len++;
                if (first_start < 0) first_start = row_start;
                else if (row_start != first_start) bad_start++;
            end
            row_len = 0;
            since_hfall = 0;
        end
        if (vsync && !vs_prev) begin
            if (vs_rise_t >= 0) vs_period = clk_cnt - vs_rise_t;
            vs_rise_t       = clk_cnt;
            frame_rows      = lit_rows;
            frame_start     = first_start;
            frame_bad_len   = bad_len;
            frame_bad_start = bad_start;
            frame_not_white = not_white;
            lit_rows    = 0;
            first_start = -1;
            bad_len     = 0;
            bad_start   = 0;
            not_white   = 0;
            ->frame_done;
        end
        if (!vsync && vs_prev) vs_high = clk_cnt - vs_rise_t;
        hs_prev = hsync;
        vs_prev = vsync;
    end

    task automatic check_value(string name, int got, int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
            tests_ok++;
        end else begin
            $display("Test %s: failed", name);
            tests_bad++;
        end
    endtask

    task automatic wait_frames(int n);
        repeat (n) @(frame_done);
    endtask

    task automatic press_button(int idx);
        @(posedge clk);
        btn[idx] <= 1'b1;
        repeat (10) @(posedge clk);
        btn[idx] <= 1'b0;
    endtask

    // One frame at 40 clks per bit, data changes while the PS/2 clock is high
    task automatic send_ps2(logic [7:0] data, logic stop);
        logic [10:0] frame;
        frame = {stop, ~^data, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            ps2_data <= frame[i];
            repeat (20) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (20) @(posedge clk);
            ps2_clk <= 1'b1;
        end
        repeat (40) @(posedge clk);
    endtask

    function automatic logic [7:0] random_plain_byte();
        logic [7:0] b;
        b = 8'($urandom);
        while (b == KEY_BREAK || b == KEY_LEFT || b == KEY_RIGHT) b = 8'($urandom);
        return b;
    endfunction

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the video outputs stopped or a test hung");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int         e;
        int         base_start;
        int         moved_start;
        int         n;
        logic [7:0] b;
        void'($urandom(32'hdca124de));
        reset_game = 1'b1;
        btn        = '0;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        repeat (3) @(posedge clk);
        reset_game <= 1'b0;

        e = errors;  // PS/2 byte to led, then a bad stop bit
        b = random_plain_byte();
        send_ps2(b, 1'b1);
        n = 0;
        while (led != b && n < 1000) begin
            @(negedge clk);
            n++;
        end
        check_value("led", led, b);
        send_ps2(~b, 1'b0);  // Differs from b, so a wrongly taken frame shows on led
        repeat (100) @(negedge clk);
        check_value("led", led, b);
        finish_test("ps2_receive", e);

        e = errors;
        wait_frames(2);
        check_value("hsync period", hs_period, MAX_H * 2);
        check_value("hsync high", hs_high, SYNC_H * 2);
        check_value("vsync period", vs_period, MAX_H * 2 * MAX_V);
        check_value("vsync high", vs_high, SYNC_V * MAX_H * 2);
        finish_test("sync_timing", e);

        e = errors;  // Frame 1 is the second frame
        check_value("lit rows", frame_rows, CANNON_H * 2);
        check_value("rows with wrong run length", frame_bad_len, 0);
        check_value("rows with other run start", frame_bad_start, 0);
        check_value("lit clks not white", frame_not_white, 0);
        base_start = frame_start;
        finish_test("cannon_picture", e);

        e = errors;
        press_button(3);
        wait_frames(1);
        check_value("run start", frame_start, base_start);
        finish_test("left_limit", e);

        e = errors;  // Delay counter long expired after a frame
        press_button(0);
        wait_frames(1);
        check_value("run start", frame_start, base_start + 4);
        send_ps2(KEY_RIGHT, 1'b1);
        send_ps2(KEY_BREAK, 1'b1);
        send_ps2(KEY_RIGHT, 1'b1);
        wait_frames(1);
        assert (frame_start >= base_start + 8) else begin
            $display("Cannon did not step on the D key, run start %0d", frame_start);
            errors++;
        end
        moved_start = frame_start;
        wait_frames(1);
        check_value("run start", frame_start, moved_start);
        finish_test("move_right", e);

        e = errors;
        @(posedge clk);
        reset_game <= 1'b1;
        repeat (3) @(posedge clk);
        reset_game <= 1'b0;
        wait_frames(1);
        check_value("run start", frame_start, base_start);
        check_value("lit rows", frame_rows, CANNON_H * 2);
        finish_test("reset_position", e);

        $display("Tests: %0d passed, %0d failed, %0d failed checks", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
space_invaders_pkg.sv
vga_timing.sv
ps2_receiver.sv
player_input.sv
cannon_ctrl.sv
line_renderer.sv
space_invaders.sv
tb_space_invaders.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_space_invaders -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1
